// ==== hdl/mulPkg.sv ====
// Multiply-side package with operand widths, decode constants, op enum and issue/result records
`default_nettype none

package mulPkg;

    typedef logic [31:0] word_t;     // Register operand or result
    typedef logic [7:0]  byte_t;     // Multiplier input
    typedef logic [15:0] product_t;  // Approximate product
    typedef logic [14:0] partial_t;  // Compressor vectors
    typedef logic [6:0]  mask_t;     // One bit per ECA cell
    typedef logic [15:0] counter_t;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // All ECA cells exact after reset
    localparam mask_t ECA_RESET_MASK = 7'b111_1111;

    localparam opcode_t OPCODE_OP     = 7'b011_0011;
    localparam funct7_t FUNCT7_MULDIV = 7'b000_0001;

    typedef enum logic [2:0] {
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU,
        OP_ILLEGAL
    } mulOp_t;

    // Decoded R-type fields plus both operand sources
    typedef struct packed {
        logic    valid;
        opcode_t opcode;
        funct3_t funct3;
        funct7_t funct7;
        word_t   rs1;
        word_t   rs2;
        word_t   forward1;
        word_t   forward2;
        logic    sel1;      // 1 takes forward1
        logic    sel2;
    } mulIssue_t;

    typedef struct packed {
        logic  valid;
        logic  illegal;
        word_t data;
    } mulResult_t;

endpackage

`default_nettype wire

// ==== hdl/apbPkg.sv ====
// APB package with the request/response records and the register map of the multiply unit
`default_nettype none

package apbPkg;

    typedef logic [7:0]  apbAddr_t;
    typedef logic [31:0] apbData_t;

    typedef struct packed {
        logic     psel;
        logic     penable;
        logic     pwrite;
        apbAddr_t paddr;
        apbData_t pwdata;
    } apbReq_t;

    typedef struct packed {
        apbData_t prdata;
        logic     pready;
        logic     pslverr;
    } apbRsp_t;

    // Register offsets
    localparam apbAddr_t REG_MASK    = 8'h00;
    localparam apbAddr_t REG_ILLEGAL = 8'h04;

endpackage

`default_nettype wire

// ==== hdl/mulDecoder.sv ====
// Multiply decoder picking forwarded or register operands and mapping funct/opcode to an op
`timescale 1ns/1ps
`default_nettype none

module mulDecoder (
    input  mulPkg::mulIssue_t issue_i,
    output mulPkg::mulOp_t    op_o,
    output mulPkg::byte_t     multiplicand_o,
    output mulPkg::byte_t     multiplier_o
);

    mulPkg::word_t operand1;
    mulPkg::word_t operand2;

    // Forwarding muxes
    always_comb begin
        operand1 = issue_i.sel1 ? issue_i.forward1 : issue_i.rs1;
        operand2 = issue_i.sel2 ? issue_i.forward2 : issue_i.rs2;
    end

    // Core only sees the low bytes, taken as unsigned
    assign multiplicand_o = operand1[7:0];
    assign multiplier_o   = operand2[7:0];

    always_comb begin
        op_o = mulPkg::OP_ILLEGAL;
        if (issue_i.opcode == mulPkg::OPCODE_OP &&
            issue_i.funct7 == mulPkg::FUNCT7_MULDIV) begin
            case (issue_i.funct3)
                3'b000:  op_o = mulPkg::OP_MUL;
                3'b001:  op_o = mulPkg::OP_MULH;
                3'b010:  op_o = mulPkg::OP_MULHSU;
                3'b011:  op_o = mulPkg::OP_MULHU;
                default: op_o = mulPkg::OP_ILLEGAL;  // DIV/REM not handled here
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/approxCompressor.sv ====
// Approximate compressor tree reducing eight partial products through three iCAC levels
`timescale 1ns/1ps
`default_nettype none

module approxCompressor (
    input  mulPkg::byte_t    multiplicand_i,
    input  mulPkg::byte_t    multiplier_i,
    output mulPkg::partial_t p7_o,
    output mulPkg::partial_t q7_o,
    output mulPkg::partial_t v1_o,
    output mulPkg::partial_t v2_o
);

    // iCAC P vector: low bits of d1, OR over the overlap, shifted d2 on top
    function automatic mulPkg::partial_t icacP(
        input mulPkg::partial_t d1,
        input mulPkg::partial_t d2,
        input int               width,
        input int               shift
    );
        mulPkg::partial_t shifted;
        mulPkg::partial_t p;
        shifted = d2 << shift;
        p = '0;
        for (int i = 0; i < $bits(mulPkg::partial_t); i++) begin
            if (i < shift) begin
                p[i] = d1[i];
            end else if (i < width) begin
                p[i] = d1[i] | shifted[i];
            end else if (i < width + shift) begin
                p[i] = shifted[i];
            end
        end
        return p;
    endfunction

    // iCAC Q vector, nonzero only where the operands overlap
    function automatic mulPkg::partial_t icacQ(
        input mulPkg::partial_t d1,
        input mulPkg::partial_t d2,
        input int               width,
        input int               shift
    );
        mulPkg::partial_t shifted;
        mulPkg::partial_t q;
        shifted = d2 << shift;
        q = '0;
        for (int i = 0; i < $bits(mulPkg::partial_t); i++) begin
            if (i >= shift && i < width) begin
                q[i] = d1[i] & shifted[i];
            end
        end
        return q;
    endfunction

    mulPkg::partial_t pp [8];
    mulPkg::partial_t p1, p2, p3, p4;  // ATC-8 outputs, 9 bits wide
    mulPkg::partial_t q1, q2, q3, q4;
    mulPkg::partial_t p5, p6;          // ATC-4 outputs, 11 bits wide
    mulPkg::partial_t q5, q6;

    always_comb begin
        for (int k = 0; k < 8; k++) begin
            pp[k] = mulPkg::partial_t'(multiplicand_i & {8{multiplier_i[k]}});
        end
    end

    // ATC-8 level
    assign p1 = icacP(pp[0], pp[1], 8, 1);
    assign q1 = icacQ(pp[0], pp[1], 8, 1);
    assign p2 = icacP(pp[2], pp[3], 8, 1);
    assign q2 = icacQ(pp[2], pp[3], 8, 1);
    assign p3 = icacP(pp[4], pp[5], 8, 1);
    assign q3 = icacQ(pp[4], pp[5], 8, 1);
    assign p4 = icacP(pp[6], pp[7], 8, 1);
    assign q4 = icacQ(pp[6], pp[7], 8, 1);
    assign v1_o = q1 | (q2 << 2) | (q3 << 4) | (q4 << 6);

    // ATC-4 level
    assign p5 = icacP(p1, p2, 9, 2);
    assign q5 = icacQ(p1, p2, 9, 2);
    assign p6 = icacP(p3, p4, 9, 2);
    assign q6 = icacQ(p3, p4, 9, 2);
    assign v2_o = q5 | (q6 << 4);

    // Final iCAC row
    assign p7_o = icacP(p5, p6, 11, 4);
    assign q7_o = icacQ(p5, p6, 11, 4);

    // Carry-save row downstream only adds Q7 over bits 4..10
    always_comb begin
        assert (q7_o[3:0] == '0 && q7_o[14:11] == '0)
            else $error("Q7 has bits outside 10..4: %h", q7_o);
    end

endmodule

`default_nettype wire

// ==== hdl/approxMultiplier.sv ====
// Two-stage approximate 8-bit multiplier with carry-save row, ECA ripple adder and op formatting
`timescale 1ns/1ps
`default_nettype none

module approxMultiplier (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               valid_i,
    input  mulPkg::mulOp_t     op_i,
    input  mulPkg::byte_t      multiplicand_i,
    input  mulPkg::byte_t      multiplier_i,
    input  mulPkg::mask_t      mask_i,
    output mulPkg::mulResult_t result_o,
    output logic               illegal_o
);

    // Returns {carry, sum} with the approximate ECA behaviour when exact is 0
    function automatic logic [1:0] adderCell(input logic exact, a, b, cin);
        logic x;
        logic sum;
        logic cout;
        x = a ^ b;
        sum = exact ? (x ^ cin) : (x | cin);
        cout = (exact & b & cin) | (a & (b | cin));
        return {cout, sum};
    endfunction

    logic             valid1;
    mulPkg::mulOp_t   op1;
    mulPkg::byte_t    multiplicand1;
    mulPkg::byte_t    multiplier1;
    mulPkg::mask_t    mask1;

    mulPkg::partial_t p7, q7, v1, v2;
    mulPkg::partial_t orMerge;
    mulPkg::partial_t sumRow;
    mulPkg::partial_t carryRow;
    logic [15:5]      ripple;
    mulPkg::product_t product;
    mulPkg::word_t    formatted;

    logic             resValid;
    logic             resIllegal;
    mulPkg::word_t    resData;

    // Stage 1
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid1 <= 1'b0;
        end else begin
            valid1 <= valid_i;
        end
        op1           <= op_i;
        multiplicand1 <= multiplicand_i;
        multiplier1   <= multiplier_i;
        mask1         <= mask_i;  // Mask sampled with the operands
    end

    approxCompressor compressor_inst (
        .multiplicand_i (multiplicand1),
        .multiplier_i   (multiplier1),
        .p7_o           (p7),
        .q7_o           (q7),
        .v1_o           (v1),
        .v2_o           (v2)
    );

    always_comb begin
        orMerge = '0;
        orMerge[10:4] = v1[10:4] | v2[10:4];
    end

    // Carry-save row
    always_comb begin
        sumRow   = '0;
        carryRow = '0;
        sumRow[0] = p7[0];
        {carryRow[2], sumRow[1]} = adderCell(1'b1, p7[1], v1[1], 1'b0);
        for (int i = 2; i <= 12; i++) begin
            if (i >= 4 && i <= 10) begin
                {carryRow[i+1], sumRow[i]} = adderCell(1'b1, p7[i], q7[i], orMerge[i]);
            end else begin
                {carryRow[i+1], sumRow[i]} = adderCell(1'b1, p7[i], v1[i], v2[i]);
            end
        end
        {carryRow[14], sumRow[13]} = adderCell(1'b1, p7[13], v1[13], 1'b0);
        sumRow[14] = p7[14];
    end

    // Final adder with OR, ECA and exact regions
    always_comb begin
        product[1:0] = sumRow[1:0];
        product[4:2] = sumRow[4:2] | carryRow[4:2];
        ripple[5] = 1'b0;
        for (int i = 5; i <= 11; i++) begin
            {ripple[i+1], product[i]} = adderCell(mask1[i-5], sumRow[i], carryRow[i], ripple[i]);
        end
        for (int i = 12; i <= 14; i++) begin
            {ripple[i+1], product[i]} = adderCell(1'b1, sumRow[i], carryRow[i], ripple[i]);
        end
        product[15] = ripple[15];
    end

    always_comb begin
        case (op1)
            mulPkg::OP_MUL: formatted = mulPkg::word_t'(product);
            mulPkg::OP_MULH,
            mulPkg::OP_MULHSU,
            mulPkg::OP_MULHU: formatted = mulPkg::word_t'(product[15:8]);
            default: formatted = '0;
        endcase
    end

    // Stage 2
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            resValid   <= 1'b0;
            resIllegal <= 1'b0;
        end else begin
            resValid   <= valid1;
            resIllegal <= valid1 && op1 == mulPkg::OP_ILLEGAL;
        end
        if (valid1) begin
            resData <= formatted;
        end
    end

    assign result_o.valid   = resValid;
    assign result_o.illegal = resIllegal;
    assign result_o.data    = resData;
    assign illegal_o        = resIllegal;  // One pulse per illegal result

    illegalDataZero: assert property (@(posedge clk_i) disable iff (reset_i)
        result_o.valid && result_o.illegal |-> result_o.data == '0)
        else $error("Illegal result carries data %h", result_o.data);

    illegalNeedsValid: assert property (@(posedge clk_i) disable iff (reset_i)
        illegal_o |-> result_o.valid)
        else $error("Illegal pulse without a valid result");

endmodule

`default_nettype wire

// ==== hdl/mulConfigRegs.sv ====
// APB slave holding the ECA mask and a saturating count of illegal multiply encodings
`timescale 1ns/1ps
`default_nettype none

module mulConfigRegs (
    input  logic            clk_i,
    input  logic            reset_i,
    input  apbPkg::apbReq_t apb_i,
    output apbPkg::apbRsp_t apb_o,
    input  logic            illegal_i,
    output mulPkg::mask_t   mask_o
);

    logic             access;
    logic             hitMask;
    logic             hitIllegal;
    mulPkg::mask_t    maskQ;
    mulPkg::counter_t illegalCount;

    assign access     = apb_i.psel & apb_i.penable;  // Access phase with pready always high
    assign hitMask    = apb_i.paddr == apbPkg::REG_MASK;
    assign hitIllegal = apb_i.paddr == apbPkg::REG_ILLEGAL;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            maskQ <= mulPkg::ECA_RESET_MASK;
        end else if (access && apb_i.pwrite && hitMask) begin
            maskQ <= apb_i.pwdata[6:0];
        end
    end

    // Clear on write wins over a same-cycle pulse
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            illegalCount <= '0;
        end else if (access && apb_i.pwrite && hitIllegal) begin
            illegalCount <= '0;
        end else if (illegal_i && illegalCount != '1) begin
            illegalCount <= illegalCount + mulPkg::counter_t'(1);  // Saturates at max
        end
    end

    always_comb begin
        apb_o.prdata = '0;
        if (access && !apb_i.pwrite) begin
            if (hitMask) begin
                apb_o.prdata = apbPkg::apbData_t'(maskQ);
            end else if (hitIllegal) begin
                apb_o.prdata = apbPkg::apbData_t'(illegalCount);
            end
        end
    end

    assign apb_o.pready  = 1'b1;
    assign apb_o.pslverr = access & ~(hitMask | hitIllegal);

    // A mask write reaches stage 1 at its own edge
    assign mask_o = (access && apb_i.pwrite && hitMask) ? apb_i.pwdata[6:0] : maskQ;

    slverrInAccess: assert property (@(posedge clk_i) disable iff (reset_i)
        apb_o.pslverr |-> apb_i.psel && apb_i.penable)
        else $error("pslverr outside access phase");

endmodule

`default_nettype wire

// ==== hdl/mulUnit.sv ====
// Multiply unit top joining decoder, approximate multiplier pipeline and APB config registers
`timescale 1ns/1ps
`default_nettype none

module mulUnit (
    input  logic               clk_i,
    input  logic               reset_i,
    input  mulPkg::mulIssue_t  issue_i,
    output mulPkg::mulResult_t result_o,
    input  apbPkg::apbReq_t    apb_i,
    output apbPkg::apbRsp_t    apb_o
);

    mulPkg::mulOp_t op;
    mulPkg::byte_t  multiplicand;
    mulPkg::byte_t  multiplier;
    mulPkg::mask_t  mask;
    logic           illegalPulse;

    mulDecoder decoder_inst (
        .issue_i        (issue_i),
        .op_o           (op),
        .multiplicand_o (multiplicand),
        .multiplier_o   (multiplier)
    );

    approxMultiplier multiplier_inst (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .valid_i        (issue_i.valid),  // Always ready, no stall
        .op_i           (op),
        .multiplicand_i (multiplicand),
        .multiplier_i   (multiplier),
        .mask_i         (mask),
        .result_o       (result_o),
        .illegal_o      (illegalPulse)
    );

    mulConfigRegs regs_inst (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .apb_i     (apb_i),
        .apb_o     (apb_o),
        .illegal_i (illegalPulse),
        .mask_o    (mask)
    );

endmodule

`default_nettype wire

// ==== sim/mulModel.svh ====
// Bit-level reference model of the approximate multiplier and the multiply op rules
`ifndef MUL_MODEL_SVH
`define MUL_MODEL_SVH
`default_nettype none

// Returns {carry, sum}; a clear exact bit gives the approximate ECA cell
function automatic logic [1:0] ecaCell(input logic exact, input logic a, input logic b,
                                       input logic cin);
    logic x;
    x = a ^ b;
    if (exact) begin
        return {(a & b) | (x & cin), x ^ cin};
    end
    return {a & (b | cin), x | cin};
endfunction

// Forwarding mux followed by low-byte extraction
function automatic mulPkg::byte_t operandByte(input mulPkg::word_t regValue,
                                              input mulPkg::word_t fwdValue, input logic sel);
    return sel ? fwdValue[7:0] : regValue[7:0];
endfunction

function automatic mulPkg::product_t modelProduct(input mulPkg::byte_t a, input mulPkg::byte_t b,
                                                  input mulPkg::mask_t mask);
    mulPkg::partial_t pp [8];
    mulPkg::partial_t p8 [4];
    mulPkg::partial_t q8 [4];
    mulPkg::partial_t p4 [2];
    mulPkg::partial_t q4 [2];
    mulPkg::partial_t p7, q7, v1, v2, merged, s, c;
    mulPkg::product_t prod;
    logic             cin;
    v1 = '0;
    v2 = '0;
    for (int k = 0; k < 8; k++) begin
        pp[k] = b[k] ? mulPkg::partial_t'(a) : '0;
    end
    // iCAC as plain OR / AND of the shifted pair, operands never overlap their width
    for (int j = 0; j < 4; j++) begin
        p8[j] = pp[2*j] | (pp[2*j+1] << 1);
        q8[j] = pp[2*j] & (pp[2*j+1] << 1);
        v1 = v1 | (q8[j] << (2 * j));
    end
    for (int j = 0; j < 2; j++) begin
        p4[j] = p8[2*j] | (p8[2*j+1] << 2);
        q4[j] = p8[2*j] & (p8[2*j+1] << 2);
        v2 = v2 | (q4[j] << (4 * j));
    end
    p7 = p4[0] | (p4[1] << 4);
    q7 = p4[0] & (p4[1] << 4);
    merged = (v1 | v2) & 15'h07F0;  // Bits 4..10 only
    s = '0;
    c = '0;
    s[0] = p7[0];
    for (int i = 1; i <= 13; i++) begin
        if (i >= 4 && i <= 10) begin
            {c[i+1], s[i]} = ecaCell(1'b1, p7[i], q7[i], merged[i]);
        end else if (i == 1 || i == 13) begin
            {c[i+1], s[i]} = ecaCell(1'b1, p7[i], v1[i], 1'b0);  // Half adder
        end else begin
            {c[i+1], s[i]} = ecaCell(1'b1, p7[i], v1[i], v2[i]);
        end
    end
    s[14] = p7[14];
    prod[1:0] = s[1:0];
    prod[4:2] = s[4:2] | c[4:2];
    cin = 1'b0;
    for (int i = 5; i <= 11; i++) begin
        {cin, prod[i]} = ecaCell(mask[i-5], s[i], c[i], cin);
    end
    for (int i = 12; i <= 14; i++) begin
        {cin, prod[i]} = ecaCell(1'b1, s[i], c[i], cin);
    end
    prod[15] = cin;
    return prod;
endfunction

function automatic logic modelIllegal(input logic [6:0] opcode, input logic [2:0] funct3,
                                      input logic [6:0] funct7);
    return !(opcode == 7'b011_0011 && funct7 == 7'b000_0001 && funct3 <= 3'd3);
endfunction

// MUL keeps all 16 bits, the three high variants keep bits 15..8
function automatic mulPkg::word_t modelResult(input logic [6:0] opcode, input logic [2:0] funct3,
                                              input logic [6:0] funct7,
                                              input mulPkg::product_t prod);
    if (modelIllegal(opcode, funct3, funct7)) begin
        return '0;
    end
    if (funct3 == 3'd0) begin
        return {16'h0000, prod};
    end
    return {24'h00_0000, prod[15:8]};
endfunction

`default_nettype wire
`endif

// ==== sim/tbMulUnit.sv ====
// Testbench for the multiply unit with seeded random stimulus checked against a bit-level model
`timescale 1ns/1ps
`include "mulModel.svh"
`default_nettype none

module tbMulUnit;

    localparam int WAIT_LIMIT = 20;  // Cycles before any wait gives up

    typedef struct packed {
        mulPkg::word_t data;
        logic          illegal;
        int            arrival;  // Cycle count at which valid must be seen
    } expected_t;

    logic               clk;
    logic               reset;
    mulPkg::mulIssue_t  issue;
    mulPkg::mulResult_t result;
    apbPkg::apbReq_t    apbReq;
    apbPkg::apbRsp_t    apbRsp;

    expected_t     pending [$];
    mulPkg::mask_t maskShadow;
    int            cycleCount = 0;
    int            checkCount = 0;
    int            errorCount = 0;
    int            testErrors = 0;

    mulUnit mulUnit_inst (
        .clk_i    (clk),
        .reset_i  (reset),
        .issue_i  (issue),
        .result_o (result),
        .apb_i    (apbReq),
        .apb_o    (apbRsp)
    );

    always #50 clk = ~clk;

    always @(posedge clk) cycleCount <= cycleCount + 1;

    task automatic checkValue(input string name, input mulPkg::word_t expected,
                              input mulPkg::word_t actual);
        checkCount++;
        assert (actual === expected) else begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic stopOnTimeout(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("Something failed");
        $finish;
    endtask

    task automatic finishTest(input string name);
        $display("Test %s done with %0d errors", name, errorCount - testErrors);
        testErrors = errorCount;
    endtask

    // Scoreboard sampled away from the rising edge
    always @(negedge clk) begin
        expected_t exp;
        if (!reset && result.valid) begin
            checkCount++;
            assert (pending.size() != 0) else begin
                $display("Error at %0t ns: result valid with nothing in flight", $time);
                errorCount++;
            end
            if (pending.size() != 0) begin
                exp = pending.pop_front();
                checkValue("result_o.data", exp.data, result.data);
                checkValue("result_o.illegal", 32'(exp.illegal), 32'(result.illegal));
                checkValue("result arrival cycle", exp.arrival, cycleCount);
            end
        end
    end

    function automatic mulPkg::mulIssue_t randomIssue(input mulPkg::funct3_t f3);
        mulPkg::mulIssue_t req;
        req.valid    = 1'b1;
        req.opcode   = mulPkg::OPCODE_OP;
        req.funct3   = f3;
        req.funct7   = mulPkg::FUNCT7_MULDIV;
        req.rs1      = $urandom();
        req.rs2      = $urandom();
        req.forward1 = $urandom();
        req.forward2 = $urandom();
        req.sel1     = 1'($urandom_range(1));
        req.sel2     = 1'($urandom_range(1));
        return req;
    endfunction

    // Breaks exactly one of funct7, funct3 or opcode
    function automatic mulPkg::mulIssue_t illegalIssue();
        mulPkg::mulIssue_t req;
        req = randomIssue(mulPkg::funct3_t'($urandom_range(3)));
        case ($urandom_range(2))
            0: req.funct7 = req.funct7 ^ mulPkg::funct7_t'($urandom_range(127, 1));
            1: req.funct3 = mulPkg::funct3_t'($urandom_range(7, 4));
            default: req.opcode = req.opcode ^ mulPkg::opcode_t'($urandom_range(127, 1));
        endcase
        return req;
    endfunction

    task automatic sendIssue(input mulPkg::mulIssue_t req);
        mulPkg::byte_t a;
        mulPkg::byte_t b;
        expected_t     exp;
        a = operandByte(req.rs1, req.forward1, req.sel1);
        b = operandByte(req.rs2, req.forward2, req.sel2);
        exp.data    = modelResult(req.opcode, req.funct3, req.funct7,
                                  modelProduct(a, b, maskShadow));
        exp.illegal = modelIllegal(req.opcode, req.funct3, req.funct7);
        @(posedge clk);
        issue <= req;
        exp.arrival = cycleCount + 3;  // Old count plus this edge, the accept edge and stage 2
        pending.push_back(exp);
    endtask

    task automatic drainResults();
        int waited;
        waited = 0;
        @(posedge clk);
        issue.valid <= 1'b0;
        while (pending.size() != 0) begin
            if (waited == WAIT_LIMIT) stopOnTimeout("results still pending");
            waited++;
            @(posedge clk);
        end
    endtask

    task automatic apbAccess(input apbPkg::apbAddr_t addr, input logic write,
                             input apbPkg::apbData_t wdata, output apbPkg::apbData_t rdata,
                             output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apbReq.penable <= 1'b1;
        @(negedge clk);
        while (!apbRsp.pready) begin
            if (waited == WAIT_LIMIT) stopOnTimeout("APB pready never rose");
            waited++;
            @(negedge clk);
        end
        rdata = apbRsp.prdata;
        err   = apbRsp.pslverr;
        @(posedge clk);
        apbReq <= '0;
    endtask

    task automatic writeReg(input apbPkg::apbAddr_t addr, input apbPkg::apbData_t data,
                            input logic expectErr);
        apbPkg::apbData_t rdata;
        logic             err;
        apbAccess(addr, 1'b1, data, rdata, err);
        checkValue("apb_o.pslverr on write", 32'(expectErr), 32'(err));
    endtask

    task automatic readReg(input apbPkg::apbAddr_t addr, input apbPkg::apbData_t expected,
                           input logic expectErr, input string name);
        apbPkg::apbData_t rdata;
        logic             err;
        apbAccess(addr, 1'b0, '0, rdata, err);
        checkValue(name, expected, rdata);
        checkValue("apb_o.pslverr on read", 32'(expectErr), 32'(err));
    endtask

    task automatic writeMask(input mulPkg::mask_t value);
        writeReg(apbPkg::REG_MASK, 32'(value), 1'b0);
        maskShadow = value;
    endtask

    initial begin
        mulPkg::mulIssue_t req;
        mulPkg::mask_t     maskValue;
        int                differs;
        clk        = 1'b0;
        reset      = 1'b1;
        issue      = '0;
        apbReq     = '0;
        maskShadow = 7'h7F;  // All ECA cells exact
        differs    = 0;
        void'($urandom(37));
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        readReg(apbPkg::REG_MASK, 32'h0000_007F, 1'b0, "REG_MASK after reset");
        readReg(apbPkg::REG_ILLEGAL, '0, 1'b0, "REG_ILLEGAL after reset");
        repeat (4) @(posedge clk);  // Scoreboard flags any stray valid
        finishTest("reset values");

        for (int burst = 0; burst < 10; burst++) begin
            maskValue = mulPkg::mask_t'($urandom());
            writeMask(maskValue);
            readReg(apbPkg::REG_MASK, 32'(maskValue), 1'b0, "REG_MASK readback");
            for (int n = 0; n < 20; n++) begin
                sendIssue(randomIssue(3'b000));
                if ($urandom_range(3) == 0) begin
                    @(posedge clk);
                    issue.valid <= 1'b0;  // One idle cycle
                end
            end
            drainResults();
        end
        finishTest("random MUL");

        // MULH, MULHSU, MULHU back to back
        for (int n = 0; n < 30; n++) begin
            sendIssue(randomIssue(mulPkg::funct3_t'(1 + n % 3)));
        end
        drainResults();
        finishTest("high variants");

        writeReg(apbPkg::REG_ILLEGAL, '0, 1'b0);
        for (int n = 0; n < 30; n++) begin
            sendIssue(illegalIssue());
        end
        drainResults();
        readReg(apbPkg::REG_ILLEGAL, 32'd30, 1'b0, "REG_ILLEGAL count");
        writeReg(apbPkg::REG_ILLEGAL, 32'hFFFF_FFFF, 1'b0);
        readReg(apbPkg::REG_ILLEGAL, '0, 1'b0, "REG_ILLEGAL after clear");
        finishTest("illegal encodings");

        writeMask(7'h00);
        for (int n = 0; n < 24; n++) begin
            req = randomIssue(3'b000);
            if (n < 4) begin
                req.rs1[7:0] = 8'hFF ^ 8'(n);  // Dense operands exercise the ECA cells
                req.rs2[7:0] = 8'hFF;
                req.sel1     = 1'b0;
                req.sel2     = 1'b0;
            end
            if (modelProduct(operandByte(req.rs1, req.forward1, req.sel1),
                             operandByte(req.rs2, req.forward2, req.sel2), 7'h00) !=
                modelProduct(operandByte(req.rs1, req.forward1, req.sel1),
                             operandByte(req.rs2, req.forward2, req.sel2), 7'h7F)) begin
                differs++;
            end
            sendIssue(req);
        end
        drainResults();
        checkCount++;
        assert (differs > 0) else begin
            $display("Error at %0t ns: zero mask never changed a product", $time);
            errorCount++;
        end
        writeReg(8'h08, 32'h0000_007F, 1'b1);
        readReg(8'h08, '0, 1'b1, "apb_o.prdata on unmapped read");
        readReg(apbPkg::REG_MASK, '0, 1'b0, "REG_MASK after unmapped write");
        finishTest("approximate mask and unmapped access");

        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+sim
hdl/mulPkg.sv
hdl/apbPkg.sv
hdl/mulDecoder.sv
hdl/approxCompressor.sv
hdl/approxMultiplier.sv
hdl/mulConfigRegs.sv
hdl/mulUnit.sv
sim/tbMulUnit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the multiply unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tbMulUnit \
    --Mdir obj_dir -o tbMulUnit > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tbMulUnit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0
